//--- dv/tb_cpu.sv
module tb_cpu
  import cpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 20000;  // 7 programs, none near 1500 cycles
  localparam int reset_cycles   = 3;
  localparam int halt_limit     = 1500;   // cycles one program may take to halt

  logic    clka = 1'b0;
  logic    rst_n;
  mem_wr_t host_wr;
  logic    run;
  mem_wr_t mem_wr;
  logic    halted;
  logic    fault;

  logic [word_bits-1:0] prog [$];  // two words per instruction
  mem_wr_t              wr_q [$];  // core stores in the order they hit the ram
  int                   cycle_cnt = 0;

  cpu_top UUT (
    .clka    (clka),
    .rst_n   (rst_n),
    .host_wr (host_wr),
    .run     (run),
    .mem_wr  (mem_wr),
    .halted  (halted),
    .fault   (fault)
  );

  always #5 clka = ~clka;  // 10 ns period

  always @(posedge clka) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout after %0d cycles, the core did not halt", cycle_cnt);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clka) begin
    if (rst_n && mem_wr.en) begin
      wr_q.push_back(mem_wr);  // stable between edges
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic void emit(input logic [7:0] op, input logic [3:0] rnum,
                               input logic [15:0] operand);
    prog.push_back({op, 4'h0, rnum});  // opcode byte, register byte
    prog.push_back(operand);
  endfunction

  task automatic load_prog();
    @(posedge clka);
    run   <= 1'b0;
    rst_n <= 1'b0;
    repeat (reset_cycles) @(posedge clka);
    rst_n <= 1'b1;
    foreach (prog[i]) begin
      @(posedge clka);
      host_wr.en   <= 1'b1;
      host_wr.addr <= addr_bits'(i);  // page 0 holds logical page 0
      host_wr.data <= prog[i];
    end
    @(posedge clka);
    host_wr <= '0;
    wr_q.delete();
    run     <= 1'b1;
  endtask

  task automatic run_to_halt();
    int n;
    n = 0;
    while (!halted && n < halt_limit) begin
      @(negedge clka);
      n++;
    end
    repeat (4) @(negedge clka);  // room for a stray write to show up
  endtask

  task automatic check_done(input logic exp_fault, input int exp_writes);
    check("halted", 32'(halted), 32'd1);
    check("fault", 32'(fault), 32'(exp_fault));
    check("write count", 32'(wr_q.size()), 32'(exp_writes));
  endtask

  task automatic check_write(input int idx, input logic [15:0] addr, input logic [15:0] data);
    check($sformatf("mem_wr.addr[%0d]", idx), 32'(wr_q[idx].addr), 32'(addr));
    check($sformatf("mem_wr.data[%0d]", idx), 32'(wr_q[idx].data), 32'(data));
  endtask

  task automatic test_store();
    logic [15:0] v;
    logic [3:0]  r;
    v = 16'($urandom);
    r = 4'($urandom);
    prog.delete();
    emit(op_num2reg, r, v);
    emit(op_reg2ram, r, 16'd100);  // logical page 1, offset 28
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b0, 1);
    check_write(0, 16'd100, v);  // first new page is physical 1
  endtask

  task automatic test_arith();
    logic [15:0] v;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] exp;
    v   = 16'($urandom);
    a   = 16'($urandom);
    b   = 16'($urandom);
    exp = v + a - b;  // wraps at 2^16
    prog.delete();
    emit(op_num2reg, 4'd3, v);
    emit(op_reg_plus, 4'd3, a);
    emit(op_reg_minus, 4'd3, b);
    emit(op_reg2ram, 4'd3, 16'd100);
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b0, 1);
    check_write(0, 16'd100, exp);
  endtask

  task automatic test_load();
    logic [15:0] v;
    v = 16'($urandom);
    prog.delete();
    emit(op_num2reg, 4'd1, v);
    emit(op_reg2ram, 4'd1, 16'd100);
    emit(op_ram2reg, 4'd2, 16'd100);
    emit(op_reg2ram, 4'd2, 16'd150);  // logical page 2 becomes physical 2
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b0, 2);
    check_write(0, 16'd100, v);
    check_write(1, 16'd150, v);  // 144 + 6
  endtask

  task automatic test_alloc();
    logic [15:0] v [3];
    foreach (v[i]) v[i] = 16'($urandom);
    prog.delete();
    emit(op_num2reg, 4'd4, v[0]);
    emit(op_reg2ram, 4'd4, 16'(5 * page_words + 7));  // page 5, first touch
    emit(op_num2reg, 4'd4, v[1]);
    emit(op_reg2ram, 4'd4, 16'(3 * page_words + 20));  // page 3, second touch
    emit(op_num2reg, 4'd4, v[2]);
    emit(op_reg2ram, 4'd4, 16'(5 * page_words + 30));  // page 5 again
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b0, 3);
    check_write(0, 16'(1 * page_words + 7), v[0]);
    check_write(1, 16'(2 * page_words + 20), v[1]);
    check_write(2, 16'(1 * page_words + 30), v[2]);
  endtask

  task automatic test_jump();
    logic [15:0] v;
    v = 16'($urandom);
    prog.delete();
    emit(op_jmp, 4'd0, 16'd4);         // words 0,1
    emit(op_reg2ram, 4'd1, 16'd200);   // words 2,3, skipped
    emit(op_num2reg, 4'd1, v);         // words 4,5
    emit(op_reg2ram, 4'd1, 16'd110);   // page 1, offset 38
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b0, 1);
    check_write(0, 16'd110, v);
  endtask

  task automatic test_bad_opcode();
    prog.delete();
    emit(op_num2reg, 4'd1, 16'($urandom));
    emit(8'h2a, 4'd1, 16'd0);  // not a known opcode
    emit(op_reg2ram, 4'd1, 16'd100);
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b1, 0);
  endtask

  task automatic test_page_fault();
    logic [15:0] v;
    v = 16'($urandom);
    prog.delete();
    emit(op_num2reg, 4'd1, v);
    for (int k = 1; k <= 14; k++) begin
      emit(op_reg2ram, 4'd1, 16'((k + 20) * page_words + k));  // new logical page each
    end
    emit(op_exit, 4'd0, 16'd0);
    load_prog();
    run_to_halt();
    check_done(1'b1, num_pages - 1);  // pages 1..13, then none left
    for (int k = 1; k < num_pages; k++) begin
      check_write(k - 1, 16'(k * page_words + k), v);
    end
  endtask

  initial begin
    rst_n   = 1'b0;
    run     = 1'b0;
    host_wr = '0;
    void'($urandom(32'hf49cef2a));  // one seed for the whole run
    test_store();
    test_arith();
    test_load();
    test_alloc();
    test_jump();
    test_bad_opcode();
    test_page_fault();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- logic/cpu_core.sv
module cpu_core
  import cpu_pkg::*;
(
  input  logic                 clka,
  input  logic                 rst_n,
  input  logic                 run,
  output mmu_req_t             mmu_req,
  input  mmu_resp_t            mmu_resp,
  output logic [addr_bits-1:0] rd_addr,
  input  logic [word_bits-1:0] rd_data,
  output mem_wr_t              core_wr,
  output exec_cmd_t            exec_cmd,
  input  logic [word_bits-1:0] store_data,
  output logic                 halted,
  output logic                 fault
);

  core_state_e          state;
  logic [word_bits-1:0] pc;          // logical program counter
  opcode_e              op_q;        // upper byte of word one
  logic [reg_bits-1:0]  rnum_q;      // low nibble of word one
  logic                 rd_pending;  // load data arrives next cycle
  logic                 mmu_fault;
  logic                 is_mem_op;

  assign mmu_fault = mmu_resp.done & mmu_resp.fault;
  assign is_mem_op = (op_q == op_ram2reg) || (op_q == op_reg2ram);

  // ram address follows the translation, sampled on the done cycle
  assign rd_addr = mmu_resp.paddr;

  assign core_wr.en   = (state == st_store) & mmu_resp.done & ~mmu_resp.fault;
  assign core_wr.addr = mmu_resp.paddr;
  assign core_wr.data = store_data;  // register named by rnum_q

  always_comb begin
    mmu_req.valid = 1'b0;
    mmu_req.laddr = pc;
    case (state)
      st_fetch1_req: mmu_req.valid = 1'b1;
      st_fetch2_req: begin
        mmu_req.valid = 1'b1;
        mmu_req.laddr = pc + 1'b1;  // operand word
      end
      st_decode: begin
        mmu_req.valid = is_mem_op;
        mmu_req.laddr = rd_data;  // operand is the data address
      end
      default: ;
    endcase
  end

  always_comb begin
    exec_cmd.valid     = 1'b0;
    exec_cmd.op        = op_q;
    exec_cmd.rnum      = rnum_q;
    exec_cmd.operand   = rd_data;
    exec_cmd.load_data = rd_data;
    if (state == st_decode) begin
      exec_cmd.valid = (op_q == op_num2reg) || (op_q == op_reg_plus) ||
                       (op_q == op_reg_minus);
    end else if (state == st_load_wait) begin
      exec_cmd.valid = rd_pending;  // ram word for ram2reg
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      pc         <= '0;
      op_q       <= op_exit;
      rnum_q     <= '0;
      rd_pending <= 1'b0;
      halted     <= 1'b0;
      fault      <= 1'b0;
    end else if (mmu_fault) begin
      fault  <= 1'b1;  // no page left, stop the core
      halted <= 1'b1;
      state  <= st_halt;
    end else begin
      case (state)
        st_idle: begin
          if (run) state <= st_fetch1_req;
        end
        st_fetch1_req: state <= st_fetch1_wait;
        st_fetch1_wait: begin
          if (mmu_resp.done) state <= st_fetch2_req;
        end
        st_fetch2_req: begin
          op_q   <= opcode_e'(rd_data[15:8]);
          rnum_q <= rd_data[reg_bits-1:0];
          pc     <= pc + 1'b1;
          state  <= st_fetch2_wait;
        end
        st_fetch2_wait: begin
          if (mmu_resp.done) state <= st_decode;
        end
        st_decode: begin
          pc <= pc + 1'b1;  // next instruction unless jmp
          case (op_q)
            op_jmp: begin
              pc    <= rd_data;
              state <= st_fetch1_req;
            end
            op_num2reg, op_reg_plus, op_reg_minus: state <= st_fetch1_req;
            op_ram2reg: state <= st_load_wait;
            op_reg2ram: state <= st_store;
            op_exit: begin
              halted <= 1'b1;
              state  <= st_halt;
            end
            default: begin
              fault  <= 1'b1;  // unknown opcode
              halted <= 1'b1;
              state  <= st_halt;
            end
          endcase
        end
        st_load_wait: begin
          if (rd_pending) begin
            rd_pending <= 1'b0;
            state      <= st_fetch1_req;
          end else if (mmu_resp.done) begin
            rd_pending <= 1'b1;
          end
        end
        st_store: begin
          if (mmu_resp.done) state <= st_fetch1_req;  // write went out this cycle
        end
        st_halt: state <= st_halt;  // only reset leaves
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

  localparam int addr_bits  = 10;  // physical ram address width
  localparam int word_bits  = 16;  // data and operand width
  localparam int page_words = 72;  // words per physical page
  localparam int num_pages  = 14;  // physical pages 0..13, all fit below 1024
  localparam int page_bits  = 4;   // wide enough to also hold num_pages
  localparam int num_regs   = 16;  // register file depth
  localparam int reg_bits   = 4;   // low nibble of the register byte

  typedef enum logic [7:0] {
    op_jmp       = 8'd1,   // pc = operand
    op_ram2reg   = 8'd2,   // reg = ram[operand]
    op_reg2ram   = 8'd3,   // ram[operand] = reg
    op_num2reg   = 8'd4,   // reg = operand
    op_reg_plus  = 8'd5,   // reg += operand
    op_reg_minus = 8'd6,   // reg -= operand
    op_exit      = 8'd17   // single task, so this halts the core
  } opcode_e;

  typedef enum logic [3:0] {
    st_idle,
    st_fetch1_req,   // translate pc for the opcode word
    st_fetch1_wait,
    st_fetch2_req,   // opcode word on rd_data, translate pc+1
    st_fetch2_wait,
    st_decode,       // operand word on rd_data
    st_load_wait,
    st_store,
    st_halt
  } core_state_e;

  typedef enum logic [1:0] {
    mmu_idle,
    mmu_walk,   // follow the chain from page 0
    mmu_alloc,  // scan for a free page from the allocation pointer
    mmu_done    // one-cycle answer
  } mmu_state_e;

  typedef struct packed {
    logic                 en;
    logic [addr_bits-1:0] addr;
    logic [word_bits-1:0] data;
  } mem_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [word_bits-1:0] laddr;  // logical address
  } mmu_req_t;

  typedef struct packed {
    logic                 done;
    logic [addr_bits-1:0] paddr;
    logic                 fault;  // no free page left
  } mmu_resp_t;

  typedef struct packed {
    logic                 valid;
    opcode_e              op;
    logic [reg_bits-1:0]  rnum;
    logic [word_bits-1:0] operand;
    logic [word_bits-1:0] load_data;
  } exec_cmd_t;

endpackage

//--- logic/cpu_top.sv
module cpu_top
  import cpu_pkg::*;
(
  input  logic    clka,
  input  logic    rst_n,
  input  mem_wr_t host_wr,  // program load, only while run is low
  input  logic    run,
  output mem_wr_t mem_wr,   // core store as seen by the ram
  output logic    halted,
  output logic    fault
);

  mmu_req_t             mmu_req;
  mmu_resp_t            mmu_resp;
  logic [addr_bits-1:0] rd_addr;
  logic [word_bits-1:0] rd_data;
  mem_wr_t              core_wr;
  exec_cmd_t            exec_cmd;
  logic [word_bits-1:0] store_data;

  assign mem_wr = core_wr;

  program_ram u_ram (
    .clka    (clka),
    .host_wr (host_wr),
    .core_wr (core_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  page_mmu u_mmu (
    .clka     (clka),
    .rst_n    (rst_n),
    .mmu_req  (mmu_req),
    .mmu_resp (mmu_resp)
  );

  cpu_core u_core (
    .clka       (clka),
    .rst_n      (rst_n),
    .run        (run),
    .mmu_req    (mmu_req),
    .mmu_resp   (mmu_resp),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .core_wr    (core_wr),
    .exec_cmd   (exec_cmd),
    .store_data (store_data),
    .halted     (halted),
    .fault      (fault)
  );

  exec_unit u_exec (
    .clka       (clka),
    .rst_n      (rst_n),
    .exec_cmd   (exec_cmd),
    .store_data (store_data)
  );

endmodule

//--- logic/exec_unit.sv
module exec_unit
  import cpu_pkg::*;
(
  input  logic                 clka,
  input  logic                 rst_n,
  input  exec_cmd_t            exec_cmd,
  output logic [word_bits-1:0] store_data
);

  logic [word_bits-1:0] regs [num_regs];

  assign store_data = regs[exec_cmd.rnum];  // also the add/sub source

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (exec_cmd.valid) begin
      case (exec_cmd.op)
        op_num2reg:   regs[exec_cmd.rnum] <= exec_cmd.operand;
        op_ram2reg:   regs[exec_cmd.rnum] <= exec_cmd.load_data;
        op_reg_plus:  regs[exec_cmd.rnum] <= store_data + exec_cmd.operand;  // wraps at 2^16
        op_reg_minus: regs[exec_cmd.rnum] <= store_data - exec_cmd.operand;
        default: ;  // other opcodes never reach here
      endcase
    end
  end

endmodule

//--- logic/page_mmu.sv
module page_mmu
  import cpu_pkg::*;
(
  input  logic      clka,
  input  logic      rst_n,
  input  mmu_req_t  mmu_req,
  output mmu_resp_t mmu_resp
);

  mmu_state_e           state;
  logic [num_pages-1:0] used_q;                 // clear means free page
  logic [word_bits-1:0] lpage_q [num_pages];    // logical page held by each physical page
  logic [page_bits-1:0] next_q [num_pages];     // chain link, self link marks the tail
  logic [page_bits-1:0] alloc_ptr;              // first candidate for the free scan
  logic [page_bits-1:0] scan_pg;
  logic [page_bits-1:0] cur_pg;                 // walk position, later the answer
  logic [page_bits-1:0] tail_pg;                // chain end found by the walk
  logic [word_bits-1:0] tgt_lpage;              // logical page under translation
  logic [addr_bits-1:0] offset_q;
  logic [word_bits-1:0] last_lpage;             // one-entry translation cache
  logic [page_bits-1:0] last_ppage;
  logic                 fault_q;
  logic [word_bits-1:0] req_lpage;
  logic [word_bits-1:0] req_offset;

  assign req_lpage  = mmu_req.laddr / word_bits'(page_words);
  assign req_offset = mmu_req.laddr % word_bits'(page_words);

  assign mmu_resp.done  = (state == mmu_done);
  assign mmu_resp.fault = fault_q;
  assign mmu_resp.paddr = addr_bits'(cur_pg) * addr_bits'(page_words) + offset_q;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state      <= mmu_idle;
      used_q     <= num_pages'(1);  // page 0 owns logical page 0
      for (int i = 0; i < num_pages; i++) begin
        lpage_q[i] <= '0;
        next_q[i]  <= page_bits'(i);  // every page is its own tail
      end
      alloc_ptr  <= page_bits'(1);
      scan_pg    <= '0;
      cur_pg     <= '0;
      tail_pg    <= '0;
      tgt_lpage  <= '0;
      offset_q   <= '0;
      last_lpage <= '0;  // cache starts on logical page 0
      last_ppage <= '0;
      fault_q    <= 1'b0;
    end else begin
      case (state)
        mmu_idle: begin
          if (mmu_req.valid) begin
            tgt_lpage <= req_lpage;
            offset_q  <= addr_bits'(req_offset);
            fault_q   <= 1'b0;
            if (req_lpage == last_lpage) begin
              cur_pg <= last_ppage;  // hit, answer next cycle
              state  <= mmu_done;
            end else begin
              cur_pg <= '0;  // chain always starts at page 0
              state  <= mmu_walk;
            end
          end
        end
        mmu_walk: begin
          if (lpage_q[cur_pg] == tgt_lpage) begin
            last_lpage <= tgt_lpage;
            last_ppage <= cur_pg;
            state      <= mmu_done;
          end else if (next_q[cur_pg] == cur_pg) begin
            tail_pg <= cur_pg;  // end of chain, go find a free page
            scan_pg <= alloc_ptr;
            state   <= mmu_alloc;
          end else begin
            cur_pg <= next_q[cur_pg];  // one link per cycle
          end
        end
        mmu_alloc: begin
          if (scan_pg == page_bits'(num_pages)) begin
            fault_q <= 1'b1;  // out of physical pages
            state   <= mmu_done;
          end else if (!used_q[scan_pg]) begin
            used_q[scan_pg]  <= 1'b1;
            lpage_q[scan_pg] <= tgt_lpage;
            next_q[tail_pg]  <= scan_pg;  // append at the tail
            next_q[scan_pg]  <= scan_pg;  // new tail
            alloc_ptr        <= scan_pg + 1'b1;
            cur_pg           <= scan_pg;
            last_lpage       <= tgt_lpage;
            last_ppage       <= scan_pg;
            state            <= mmu_done;
          end else begin
            scan_pg <= scan_pg + 1'b1;
          end
        end
        mmu_done: state <= mmu_idle;
        default:  state <= mmu_idle;
      endcase
    end
  end

endmodule

//--- logic/program_ram.sv
module program_ram
  import cpu_pkg::*;
(
  input  logic                 clka,
  input  mem_wr_t              host_wr,
  input  mem_wr_t              core_wr,
  input  logic [addr_bits-1:0] rd_addr,
  output logic [word_bits-1:0] rd_data
);

  logic [word_bits-1:0] mem [2**addr_bits];  // 1024 x 16, no reset
  mem_wr_t              wr_sel;              // single write port

  assign wr_sel = host_wr.en ? host_wr : core_wr;  // host wins

  always_ff @(posedge clka) begin
    if (wr_sel.en) begin
      mem[wr_sel.addr] <= wr_sel.data;
    end
    rd_data <= mem[rd_addr];  // one cycle read latency
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build tb_cpu with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f verilog.f --top-module tb_cpu -o tb_cpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0

//--- verilog.f
logic/cpu_pkg.sv
logic/program_ram.sv
logic/page_mmu.sv
logic/exec_unit.sv
logic/cpu_core.sv
logic/cpu_top.sv
dv/tb_cpu.sv
